//--- rtl/obi_bus_pkg.sv
// Types seen on the monitored bus side of the hardening logic
// Each bus is reduced to two single-cycle strobes sampled on the rising edge
// At most 8 buses can be named by the index width below
package obi_bus_pkg;

  // Width of a bus index in fault records
  // Three bits cover the largest supported set of eight buses
  localparam int unsigned BUS_IDX_W = 3;

  // Events seen on one bus during one clock cycle
  // Both bits may be high together when an address phase and a response
  // phase complete in the same cycle
  typedef struct packed {
    // An address phase was accepted by the slave this cycle
    logic addr_acc;
    // A response phase completed this cycle
    logic rsp_valid;
  } bus_evt_t;

endpackage

//--- rtl/hardening_alert_pkg.sv
// Types describing faults and the alert controller
// Cause codes are 2 bits wide and CAUSE_NONE is the reset value of every record
// The bus index field takes its width from the bus package
package hardening_alert_pkg;

  // Reason a bus tracker flagged a protocol fault
  typedef enum logic [1:0] {
    CAUSE_NONE         = 2'd0,
    CAUSE_RSP_NO_REQ   = 2'd1,
    CAUSE_CNT_OVERFLOW = 2'd2
  } fault_cause_e;

  // Registered fault report from one tracker, valid for a single cycle
  typedef struct packed {
    logic         valid;
    fault_cause_e cause;
  } fault_t;

  // First fault seen after reset, as presented at the top level
  typedef struct packed {
    logic [obi_bus_pkg::BUS_IDX_W-1:0] bus_idx;
    fault_cause_e                      cause;
  } fault_info_t;

  // States of the alert controller
  // ST_ALERTED is only left through reset
  typedef enum logic {
    ST_MONITOR = 1'b0,
    ST_ALERTED = 1'b1
  } ctrl_state_e;

endpackage

//--- rtl/outstanding_tracker.sv
// Counts address phases on one bus that still wait for their response
// The counter saturates at zero and at its maximum and never wraps
// Fault reports are raw, the alert controller decides whether they count
module outstanding_tracker #(
  parameter int unsigned CNT_W = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  obi_bus_pkg::bus_evt_t        evt_i,
  output hardening_alert_pkg::fault_t  fault_o
);

  // Largest count the register can hold
  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  logic [CNT_W-1:0]            cnt_q;
  logic [CNT_W-1:0]            cnt_d;
  hardening_alert_pkg::fault_t fault_q;
  hardening_alert_pkg::fault_t fault_d;

  // Next count and fault report from this cycle's strobes
  always_comb begin
    cnt_d         = cnt_q;
    fault_d.valid = 1'b0;
    fault_d.cause = hardening_alert_pkg::CAUSE_NONE;

    unique case ({evt_i.addr_acc, evt_i.rsp_valid})
      2'b11: begin
        // A new phase and a response cancel out while phases are pending
        // At zero count the pair leaves one phase counted
        if (cnt_q == '0) begin
          cnt_d = CNT_W'(1);
        end
      end
      2'b01: begin
        // A response with nothing pending is a protocol fault
        // The count holds at zero so it cannot underflow
        if (cnt_q == '0) begin
          fault_d.valid = 1'b1;
          fault_d.cause = hardening_alert_pkg::CAUSE_RSP_NO_REQ;
        end else begin
          cnt_d = cnt_q - CNT_W'(1);
        end
      end
      2'b10: begin
        // One more phase than the counter can track is flagged
        if (cnt_q == CNT_MAX) begin
          fault_d.valid = 1'b1;
          fault_d.cause = hardening_alert_pkg::CAUSE_CNT_OVERFLOW;
        end else begin
          cnt_d = cnt_q + CNT_W'(1);
        end
      end
      default: begin
        // No strobes, nothing changes
      end
    endcase
  end

  // The report is rebuilt every cycle, so a fault lasts exactly one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q         <= '0;
      fault_q.valid <= 1'b0;
      fault_q.cause <= hardening_alert_pkg::CAUSE_NONE;
    end else begin
      cnt_q   <= cnt_d;
      fault_q <= fault_d;
    end
  end

  assign fault_o = fault_q;

endmodule

//--- rtl/fault_capture.sv
// Records the bus index and cause of the first fault after reset
// On simultaneous faults the lowest bus index wins
// NUM_BUS must not exceed 8 so the index fits the record field
module fault_capture #(
  parameter int unsigned NUM_BUS = 5
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  hardening_alert_pkg::fault_t [NUM_BUS-1:0] faults_i,
  input  logic                                      capture_en_i,
  output hardening_alert_pkg::fault_info_t          fault_info_o
);

  hardening_alert_pkg::fault_info_t info_q;
  hardening_alert_pkg::fault_info_t win;

  // Priority encoder over the fault valids
  // Walking down from the top index lets the lowest valid bus overwrite the rest
  always_comb begin
    win.bus_idx = '0;
    win.cause   = hardening_alert_pkg::CAUSE_NONE;
    for (int i = NUM_BUS - 1; i >= 0; i--) begin
      if (faults_i[i].valid) begin
        win.bus_idx = i[obi_bus_pkg::BUS_IDX_W-1:0];
        win.cause   = faults_i[i].cause;
      end
    end
  end

  // The controller raises capture_en_i only once per reset
  // so the stored record keeps the first fault seen
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      info_q.bus_idx <= '0;
      info_q.cause   <= hardening_alert_pkg::CAUSE_NONE;
    end else if (capture_en_i) begin
      info_q <= win;
    end
  end

  assign fault_info_o = info_q;

endmodule

//--- rtl/alert_ctrl.sv
// Turns tracker fault reports into major and minor alerts
// With SECURE at 0 every report is ignored and no alert is raised
// The major alert is sticky and only reset clears it
module alert_ctrl #(
  parameter int unsigned NUM_BUS = 5,
  parameter bit          SECURE  = 1'b1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  hardening_alert_pkg::fault_t [NUM_BUS-1:0] faults_i,
  output logic                                      capture_en_o,
  output logic                                      alert_major_o,
  output logic                                      alert_minor_o
);

  hardening_alert_pkg::ctrl_state_e state_q;
  hardening_alert_pkg::ctrl_state_e state_d;
  logic [NUM_BUS-1:0]               fault_valid;
  logic                             any_fault;
  logic                             minor_q;

  // Collect the valid bit of every tracker report
  always_comb begin
    for (int i = 0; i < NUM_BUS; i++) begin
      fault_valid[i] = faults_i[i].valid;
    end
  end

  // Hardening off masks every fault at this single point
  assign any_fault = SECURE && (|fault_valid);

  // Next state and capture strobe
  always_comb begin
    state_d      = state_q;
    capture_en_o = 1'b0;
    unique case (state_q)
      hardening_alert_pkg::ST_MONITOR: begin
        // First fault records its source and arms the major alert
        if (any_fault) begin
          capture_en_o = 1'b1;
          state_d      = hardening_alert_pkg::ST_ALERTED;
        end
      end
      hardening_alert_pkg::ST_ALERTED: begin
        // Terminal until reset
        // Later faults only pulse the minor alert
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= hardening_alert_pkg::ST_MONITOR;
      minor_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // One pulse per faulting cycle in either state
      minor_q <= any_fault;
    end
  end

  // Major alert comes straight from the registered state
  assign alert_major_o = (state_q == hardening_alert_pkg::ST_ALERTED);
  assign alert_minor_o = minor_q;

endmodule

//--- rtl/bus_hardening_top.sv
// Bus protocol hardening for up to 8 request/response buses
// Bus inputs are one-cycle strobes with no back-pressure
// Both alerts follow a faulting bus event by exactly two cycles
module bus_hardening_top #(
  parameter int unsigned NUM_BUS = 5,
  parameter int unsigned CNT_W   = 2,
  parameter bit          SECURE  = 1'b1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  obi_bus_pkg::bus_evt_t [NUM_BUS-1:0]   bus_evt_i,
  output logic                                  alert_major_o,
  output logic                                  alert_minor_o,
  output hardening_alert_pkg::fault_info_t      fault_info_o
);

  // Registered fault reports, one per bus
  hardening_alert_pkg::fault_t [NUM_BUS-1:0] faults;
  logic                                      capture_en;

  // One outstanding-phase tracker per monitored bus
  for (genvar b = 0; b < NUM_BUS; b++) begin : g_tracker
    outstanding_tracker #(
      .CNT_W (CNT_W)
    ) u_tracker (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .evt_i   (bus_evt_i[b]),
      .fault_o (faults[b])
    );
  end

  // Stores which bus failed first and why
  fault_capture #(
    .NUM_BUS (NUM_BUS)
  ) u_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .faults_i     (faults),
    .capture_en_i (capture_en),
    .fault_info_o (fault_info_o)
  );

  // Alert FSM, the only block that looks at SECURE
  alert_ctrl #(
    .NUM_BUS (NUM_BUS),
    .SECURE  (SECURE)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .faults_i      (faults),
    .capture_en_o  (capture_en),
    .alert_major_o (alert_major_o),
    .alert_minor_o (alert_minor_o)
  );

endmodule

//--- test/tb_clkgen.sv
// Clock and reset source for the testbench, clock period is 4 time units
// Reset is held low for 4 rising edges at start and after each request
// Reset changes only on the falling edge, like every other driven input
module tb_clkgen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Each rising edge of the request starts another reset sequence
  initial begin
    rst_no = 1'b0;
    forever begin
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      rst_no = 1'b1;
      @(posedge rst_req_i);
      @(negedge clk_o);
      rst_no = 1'b0;
    end
  end

endmodule

//--- test/tb_checker.sv
// Reference model and comparator for the bus hardening logic
// Assumes hardening is on, so every tracker fault counts
// Counts mismatches per output and flags a timeout at MAX_CYCLES
module tb_checker #(
  parameter int unsigned NUM_BUS    = 5,
  parameter int unsigned CNT_W      = 2,
  parameter int          MAX_CYCLES = 3000
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  obi_bus_pkg::bus_evt_t [NUM_BUS-1:0]     bus_evt_i,
  input  logic                                    alert_major_i,
  input  logic                                    alert_minor_i,
  input  hardening_alert_pkg::fault_info_t        fault_info_i,
  output int                                      err_major_o,
  output int                                      err_minor_o,
  output int                                      err_info_o,
  output logic                                    timeout_o
);

  localparam int CNT_MAX = (1 << CNT_W) - 1;
  localparam int IDX_W   = obi_bus_pkg::BUS_IDX_W;

  // Model state, tracker counts and the registered reports form the first delay stage
  int                               cnt_m [NUM_BUS];
  hardening_alert_pkg::fault_t      flt_m [NUM_BUS];
  logic                             major_m;
  logic                             minor_m;
  hardening_alert_pkg::fault_info_t info_m;
  int                               err_major_q = 0;
  int                               err_minor_q = 0;
  int                               err_info_q  = 0;
  int                               cycles      = 0;
  logic                             timeout_q   = 1'b0;

  // Outstanding count rule for one bus over one cycle
  function automatic void ref_track(input int cnt, input obi_bus_pkg::bus_evt_t evt,
                                    output int cnt_next,
                                    output hardening_alert_pkg::fault_t flt);
    cnt_next  = cnt;
    flt.valid = 1'b0;
    flt.cause = hardening_alert_pkg::CAUSE_NONE;
    if (evt.addr_acc && evt.rsp_valid) begin
      if (cnt == 0) cnt_next = 1;
    end else if (evt.rsp_valid) begin
      if (cnt == 0) begin
        flt.valid = 1'b1;
        flt.cause = hardening_alert_pkg::CAUSE_RSP_NO_REQ;
      end else begin
        cnt_next = cnt - 1;
      end
    end else if (evt.addr_acc) begin
      if (cnt == CNT_MAX) begin
        flt.valid = 1'b1;
        flt.cause = hardening_alert_pkg::CAUSE_CNT_OVERFLOW;
      end else begin
        cnt_next = cnt + 1;
      end
    end
  endfunction

  function automatic int mismatch(input string name, input logic [7:0] exp_v,
                                  input logic [7:0] act_v);
    if (exp_v !== act_v) begin
      $display("error: %s expected %h actual %h at cycle %0d", name, exp_v, act_v, cycles);
      return 1;
    end
    return 0;
  endfunction

  // Compare first, then advance the model by one clock
  always @(posedge clk_i) begin : compare_and_step
    logic                              found;
    int                                win_idx;
    hardening_alert_pkg::fault_cause_e win_cause;
    int                                next_cnt;
    hardening_alert_pkg::fault_t       next_flt;
    if (!rst_ni) begin
      for (int i = 0; i < NUM_BUS; i++) begin
        cnt_m[i]       = 0;
        flt_m[i].valid = 1'b0;
        flt_m[i].cause = hardening_alert_pkg::CAUSE_NONE;
      end
      major_m        = 1'b0;
      minor_m        = 1'b0;
      info_m.bus_idx = '0;
      info_m.cause   = hardening_alert_pkg::CAUSE_NONE;
    end else begin
      err_major_q += mismatch("alert_major_o", 8'(major_m), 8'(alert_major_i));
      err_minor_q += mismatch("alert_minor_o", 8'(minor_m), 8'(alert_minor_i));
      err_info_q  += mismatch("fault_info_o", 8'(info_m), 8'(fault_info_i));
      // Lowest faulting bus is the one that gets recorded
      found     = 1'b0;
      win_idx   = 0;
      win_cause = hardening_alert_pkg::CAUSE_NONE;
      for (int i = 0; i < NUM_BUS; i++) begin
        if (flt_m[i].valid && !found) begin
          found     = 1'b1;
          win_idx   = i;
          win_cause = flt_m[i].cause;
        end
      end
      if (found && !major_m) begin
        major_m        = 1'b1;
        info_m.bus_idx = IDX_W'(win_idx);
        info_m.cause   = win_cause;
      end
      minor_m = found;
      for (int i = 0; i < NUM_BUS; i++) begin
        ref_track(cnt_m[i], bus_evt_i[i], next_cnt, next_flt);
        cnt_m[i] = next_cnt;
        flt_m[i] = next_flt;
      end
    end
  end

  always @(posedge clk_i) begin : cycle_limit
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) timeout_q <= 1'b1;
  end

  assign err_major_o = err_major_q;
  assign err_minor_o = err_minor_q;
  assign err_info_o  = err_info_q;
  assign timeout_o   = timeout_q;

endmodule

//--- test/tb_top.sv
// Testbench top for the bus hardening logic with default parameters
// Directed phases run first, then random traffic in chunks with a reset between
// Stimulus changes on the falling edge, the checker samples on the rising edge
module tb_top;

  localparam int unsigned NUM_BUS = 5;
  localparam int unsigned CNT_W   = 2;
  localparam int EVT_W        = 2 * NUM_BUS;
  localparam int RAND_CHUNKS  = 8;
  localparam int CHUNK_CYCLES = 250;
  // Reset sequence plus the handoff cycles around it
  localparam int RST_CYCLES   = 6;
  localparam int DIR_CYCLES   = 70;
  localparam int TEST_CYCLES  = DIR_CYCLES + RAND_CHUNKS * (CHUNK_CYCLES + RST_CYCLES);
  // Give the run 20 percent headroom before calling it hung
  localparam int LIMIT        = TEST_CYCLES * 6 / 5;

  typedef obi_bus_pkg::bus_evt_t [NUM_BUS-1:0] evt_vec_t;

  logic                             clk;
  logic                             rst_n;
  logic                             rst_req;
  evt_vec_t                         bus_evt;
  logic                             alert_major;
  logic                             alert_minor;
  hardening_alert_pkg::fault_info_t fault_info;
  int                               err_major;
  int                               err_minor;
  int                               err_info;
  logic                             timeout;

  tb_clkgen u_clkgen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  bus_hardening_top #(
    .NUM_BUS (NUM_BUS),
    .CNT_W   (CNT_W)
  ) UUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .bus_evt_i     (bus_evt),
    .alert_major_o (alert_major),
    .alert_minor_o (alert_minor),
    .fault_info_o  (fault_info)
  );

  tb_checker #(
    .NUM_BUS    (NUM_BUS),
    .CNT_W      (CNT_W),
    .MAX_CYCLES (LIMIT)
  ) u_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .bus_evt_i     (bus_evt),
    .alert_major_i (alert_major),
    .alert_minor_i (alert_minor),
    .fault_info_i  (fault_info),
    .err_major_o   (err_major),
    .err_minor_o   (err_minor),
    .err_info_o    (err_info),
    .timeout_o     (timeout)
  );

  // Strobes on a single bus, all others quiet
  function automatic evt_vec_t on_bus(input int b, input logic addr, input logic rsp);
    on_bus              = '0;
    on_bus[b].addr_acc  = addr;
    on_bus[b].rsp_valid = rsp;
  endfunction

  // The same strobes on every bus
  function automatic evt_vec_t on_all(input logic addr, input logic rsp);
    for (int b = 0; b < NUM_BUS; b++) begin
      on_all[b].addr_acc  = addr;
      on_all[b].rsp_valid = rsp;
    end
  endfunction

  task automatic drive(input evt_vec_t v, input int n);
    repeat (n) begin
      @(negedge clk);
      bus_evt = v;
    end
  endtask

  // Asks the clock generator for a new reset and waits until it is released
  task automatic apply_reset();
    @(negedge clk);
    bus_evt = '0;
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    @(posedge rst_n);
  endtask

  task automatic report_counts();
    $display("Errors: alert_major_o %0d, alert_minor_o %0d, fault_info_o %0d, total %0d",
             err_major, err_minor, err_info, err_major + err_minor + err_info);
  endtask

  initial begin : stimulus
    evt_vec_t tie;
    bus_evt = '0;
    rst_req = 1'b0;
    void'($urandom(32'h3bdd_0173));
    @(posedge rst_n);
    // Balanced traffic fills each counter to 3, then drains it
    drive(on_all(1'b1, 1'b0), 3);
    drive(on_all(1'b1, 1'b1), 1);
    drive(on_all(1'b0, 1'b1), 3);
    // Same-cycle pair at zero count leaves one phase pending
    drive(on_all(1'b1, 1'b1), 1);
    drive(on_all(1'b0, 1'b1), 1);
    drive('0, 4);
    // Response on bus 3 with nothing pending, then a clean pair
    apply_reset();
    drive(on_bus(3, 1'b0, 1'b1), 1);
    drive('0, 4);
    drive(on_bus(3, 1'b1, 1'b0), 1);
    drive(on_bus(3, 1'b0, 1'b1), 1);
    drive('0, 4);
    // Fourth address phase on bus 1 overflows the counter
    apply_reset();
    drive(on_bus(1, 1'b1, 1'b0), 4);
    drive(on_bus(1, 1'b0, 1'b1), 3);
    drive('0, 4);
    // Buses 2 and 4 fault together, bus 0 faults later
    apply_reset();
    tie = on_bus(2, 1'b0, 1'b1) | on_bus(4, 1'b0, 1'b1);
    drive(tie, 1);
    drive('0, 2);
    drive(on_bus(0, 1'b0, 1'b1), 1);
    drive('0, 4);
    // Random strobes on all buses
    for (int c = 0; c < RAND_CHUNKS; c++) begin
      apply_reset();
      for (int n = 0; n < CHUNK_CYCLES; n++) begin
        @(negedge clk);
        bus_evt = EVT_W'($urandom);
      end
    end
    drive('0, 4);
    report_counts();
    if (err_major + err_minor + err_info == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    @(posedge timeout);
    $display("The run timed out after %0d cycles without finishing the tests", LIMIT);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- vlog.f
rtl/obi_bus_pkg.sv
rtl/hardening_alert_pkg.sv
rtl/outstanding_tracker.sv
rtl/fault_capture.sv
rtl/alert_ctrl.sv
rtl/bus_hardening_top.sv
test/tb_clkgen.sv
test/tb_checker.sv
test/tb_top.sv

//--- Makefile
# Verilator flow for the bus hardening logic
# Override any variable on the command line, for example make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_top
DUT_TOP   ?= bus_hardening_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Simulation passed

RTL_SRCS  := $(shell grep '^rtl/' $(FILELIST))
ALL_SRCS  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(ALL_SRCS)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
